// File: source/dft_defines.svh
`ifndef DFT_DEFINES_SVH
`define DFT_DEFINES_SVH

// input and output sample width
`define DFT_SAMPLE_W 18

// worst case bit growth through one radix-4 butterfly
`define DFT_GROWTH 2

// full precision width inside the butterfly
`define DFT_WIDE_W (`DFT_SAMPLE_W + `DFT_GROWTH)

// block exponent width
`define DFT_EXP_W 4

// headroom margin width
`define DFT_MARGIN_W 2

// complex points per butterfly
`define DFT_POINTS 4

// points handled by one radix-2 stage
`define DFT_PAIR 2

`endif

// File: source/dft_pkg.sv
`default_nettype none

`include "dft_defines.svh"

package dft_pkg;

	// one real or imaginary part at the ports
	typedef logic signed [`DFT_SAMPLE_W-1:0] sample_t;

	// butterfly internal value, holds the full radix-4 result
	typedef logic signed [`DFT_WIDE_W-1:0] wide_t;

	// block exponent
	typedef logic [`DFT_EXP_W-1:0] exp_t;

	// headroom margin supplied with each block
	typedef logic [`DFT_MARGIN_W-1:0] margin_t;

	// transform direction
	// forward rotates the odd difference by -j, inverse by +j
	typedef enum logic {
		DIR_FWD = 1'b0,
		DIR_INV = 1'b1
	} dft_dir_e;

endpackage

`default_nettype wire

// File: source/radix2_pair_if.sv
`default_nettype none

// results of one radix-2 stage on their way to the combine stage
interface radix2_pair_if import dft_pkg::*; ();

	// qualifies the four data signals for one cycle
	logic valid;

	// a + b
	wide_t sum_re;
	wide_t sum_im;

	// a - b
	wide_t diff_re;
	wide_t diff_im;

	// radix-2 stage side
	modport source (
		output valid,
		output sum_re,
		output sum_im,
		output diff_re,
		output diff_im
	);

	// combine stage side
	modport sink (
		input valid,
		input sum_re,
		input sum_im,
		input diff_re,
		input diff_im
	);

endinterface

`default_nettype wire

// File: source/radix2_stage.sv
`default_nettype none

// one radix-2 butterfly without twiddle
// computes a + b and a - b for a complex pair, one register stage
module radix2_stage import dft_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          in_val,
	input  sample_t       a_re,
	input  sample_t       a_im,
	input  sample_t       b_re,
	input  sample_t       b_im,
	radix2_pair_if.source pair
);

	wide_t a_re_w;
	wide_t a_im_w;
	wide_t b_re_w;
	wide_t b_im_w;

	wide_t sum_re_nxt;
	wide_t sum_im_nxt;
	wide_t diff_re_nxt;
	wide_t diff_im_nxt;

	// sign extension up to the internal width
	assign a_re_w = wide_t'(a_re);
	assign a_im_w = wide_t'(a_im);
	assign b_re_w = wide_t'(b_re);
	assign b_im_w = wide_t'(b_im);

	// one extra bit of growth at most, plenty of room in wide_t
	assign sum_re_nxt  = a_re_w + b_re_w;
	assign sum_im_nxt  = a_im_w + b_im_w;
	assign diff_re_nxt = a_re_w - b_re_w;
	assign diff_im_nxt = a_im_w - b_im_w;

	// valid strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pair.valid <= 1'b0;
		end else begin
			pair.valid <= in_val;
		end
	end

	// results only move when a block arrives
	always_ff @(posedge clk) begin
		if (in_val) begin
			pair.sum_re  <= sum_re_nxt;
			pair.sum_im  <= sum_im_nxt;
			pair.diff_re <= diff_re_nxt;
			pair.diff_im <= diff_im_nxt;
		end
	end

endmodule

`default_nettype wire

// File: source/radix4_combine.sv
`default_nettype none

`include "dft_defines.svh"

// second half of the radix-4 butterfly
// stage 1 forms X0..X3 from the two radix-2 results
// stage 2 scales by the block floating point shift and saturates
module radix4_combine import dft_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_val,
	input  dft_dir_e    dir,
	input  margin_t     margin_in,
	input  exp_t        exp_in,
	radix2_pair_if.sink even,
	radix2_pair_if.sink odd,
	output logic        out_val,
	output sample_t     dout_re [`DFT_POINTS],
	output sample_t     dout_im [`DFT_POINTS],
	output exp_t        exp_out,
	output logic        ovf
);

	// true when the value does not fit in sample_t
	function automatic logic out_of_range(input wide_t v);
		logic [`DFT_GROWTH:0] top;
		top = v[`DFT_WIDE_W-1:`DFT_SAMPLE_W-1];
		return !((&top) || !(|top));
	endfunction

	// clip to the most positive or most negative sample
	function automatic sample_t saturate(input wide_t v);
		sample_t r;
		if (!out_of_range(v)) begin
			r = v[`DFT_SAMPLE_W-1:0];
		end else if (v[`DFT_WIDE_W-1]) begin
			r = {1'b1, {(`DFT_SAMPLE_W-1){1'b0}}};
		end else begin
			r = {1'b0, {(`DFT_SAMPLE_W-1){1'b1}}};
		end
		return r;
	endfunction

	// side-band captured alongside the radix-2 stages
	dft_dir_e sb_dir;
	margin_t  sb_margin;
	exp_t     sb_exp;

	logic     pair_val;
	wide_t    rot_re;
	wide_t    rot_im;
	margin_t  shift_amt;

	// stage 1 registers
	logic     s1_val;
	wide_t    s1_re [`DFT_POINTS];
	wide_t    s1_im [`DFT_POINTS];
	margin_t  s1_shift;
	exp_t     s1_exp;

	// stage 2 combinational
	wide_t    sh_re [`DFT_POINTS];
	wide_t    sh_im [`DFT_POINTS];
	logic [2*`DFT_POINTS-1:0] sat_hit;
	logic [`DFT_EXP_W:0] exp_sum;
	exp_t     exp_nxt;

	always_ff @(posedge clk) begin
		if (in_val) begin
			sb_dir    <= dir;
			sb_margin <= margin_in;
			sb_exp    <= exp_in;
		end
	end

	// both stages always fire together
	assign pair_val = even.valid & odd.valid;

	// odd difference times -j or +j
	always_comb begin
		if (sb_dir == DIR_FWD) begin
			rot_re = odd.diff_im;
			rot_im = -odd.diff_re;
		end else begin
			rot_re = -odd.diff_im;
			rot_im = odd.diff_re;
		end
	end

	// shift = growth - margin, never negative
	always_comb begin
		if (sb_margin >= margin_t'(`DFT_GROWTH)) begin
			shift_amt = '0;
		end else begin
			shift_amt = margin_t'(`DFT_GROWTH) - sb_margin;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_val <= 1'b0;
		end else begin
			s1_val <= pair_val;
		end
	end

	// X0, X1, X2, X3 in natural order
	always_ff @(posedge clk) begin
		if (pair_val) begin
			s1_re[0] <= even.sum_re + odd.sum_re;
			s1_im[0] <= even.sum_im + odd.sum_im;
			s1_re[1] <= even.diff_re + rot_re;
			s1_im[1] <= even.diff_im + rot_im;
			s1_re[2] <= even.sum_re - odd.sum_re;
			s1_im[2] <= even.sum_im - odd.sum_im;
			s1_re[3] <= even.diff_re - rot_re;
			s1_im[3] <= even.diff_im - rot_im;
			s1_shift <= shift_amt;
			s1_exp   <= sb_exp;
		end
	end

	// arithmetic shift rounds toward minus infinity
	always_comb begin
		for (int k = 0; k < `DFT_POINTS; k++) begin
			sh_re[k]       = s1_re[k] >>> s1_shift;
			sh_im[k]       = s1_im[k] >>> s1_shift;
			sat_hit[2*k]   = out_of_range(sh_re[k]);
			sat_hit[2*k+1] = out_of_range(sh_im[k]);
		end
	end

	// exponent grows by the shift, sticks at all ones
	assign exp_sum = {1'b0, s1_exp} +
		{{(`DFT_EXP_W-`DFT_MARGIN_W+1){1'b0}}, s1_shift};
	assign exp_nxt = exp_sum[`DFT_EXP_W] ? '1 : exp_sum[`DFT_EXP_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val <= 1'b0;
			ovf     <= 1'b0;
		end else begin
			out_val <= s1_val;
			ovf     <= s1_val & (|sat_hit);
		end
	end

	always_ff @(posedge clk) begin
		if (s1_val) begin
			for (int k = 0; k < `DFT_POINTS; k++) begin
				dout_re[k] <= saturate(sh_re[k]);
				dout_im[k] <= saturate(sh_im[k]);
			end
			exp_out <= exp_nxt;
		end
	end

endmodule

`default_nettype wire

// File: source/dft_rdx4_top.sv
`default_nettype none

// radix-4 DFT butterfly with block floating point
// latency is three cycles, a new block may enter every cycle
module dft_rdx4_top import dft_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_val,
	input  dft_dir_e dir,
	input  sample_t  din_re [4],
	input  sample_t  din_im [4],
	input  margin_t  margin_in,
	input  exp_t     exp_in,
	output logic     out_val,
	output sample_t  dout_re [4],
	output sample_t  dout_im [4],
	output exp_t     exp_out,
	output logic     ovf
);

	// radix-2 results of (x0, x2) and (x1, x3)
	radix2_pair_if even_pair ();
	radix2_pair_if odd_pair ();

	// even samples
	radix2_stage even_stage (
		.clk    (clk),
		.rst_n  (rst_n),
		.in_val (in_val),
		.a_re   (din_re[0]),
		.a_im   (din_im[0]),
		.b_re   (din_re[2]),
		.b_im   (din_im[2]),
		.pair   (even_pair.source)
	);

	// odd samples
	radix2_stage odd_stage (
		.clk    (clk),
		.rst_n  (rst_n),
		.in_val (in_val),
		.a_re   (din_re[1]),
		.a_im   (din_im[1]),
		.b_re   (din_re[3]),
		.b_im   (din_im[3]),
		.pair   (odd_pair.source)
	);

	// rotation, output formation and scaling
	// side-band goes straight in, the combine stage aligns it
	radix4_combine combine (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_val    (in_val),
		.dir       (dir),
		.margin_in (margin_in),
		.exp_in    (exp_in),
		.even      (even_pair.sink),
		.odd       (odd_pair.sink),
		.out_val   (out_val),
		.dout_re   (dout_re),
		.dout_im   (dout_im),
		.exp_out   (exp_out),
		.ovf       (ovf)
	);

endmodule

`default_nettype wire

// File: testbench/dft_rdx4_tb.sv
`default_nettype none

`include "dft_defines.svh"

module dft_rdx4_tb import dft_pkg::*; ();

	localparam int LATENCY = 3;
	localparam int RAND_BLOCKS = 200;
	localparam int MAX_GAP = 3;
	// reset, idle and the directed tests fit in this
	localparam int DIRECTED_CYCLES = 120;
	localparam int TIMEOUT_CYCLES = DIRECTED_CYCLES + RAND_BLOCKS * (MAX_GAP + 1) + 50;
	localparam int SMAX = (1 << (`DFT_SAMPLE_W - 1)) - 1;
	localparam int SMIN = -(1 << (`DFT_SAMPLE_W - 1));
	localparam int EXP_MAX = (1 << `DFT_EXP_W) - 1;

	typedef struct packed {
		sample_t [3:0] re;
		sample_t [3:0] im;
		exp_t          exponent;
		logic          ovf;
		int            stamp;
	} blk_t;

	logic     clk;
	logic     rst_n;
	logic     in_val;
	dft_dir_e dir;
	sample_t  din_re [4];
	sample_t  din_im [4];
	margin_t  margin_in;
	exp_t     exp_in;
	logic     out_val;
	sample_t  dout_re [4];
	sample_t  dout_im [4];
	exp_t     exp_out;
	logic     ovf;

	sample_t  stim_re [4];
	sample_t  stim_im [4];
	blk_t     expect_q [$];
	blk_t     seen_q [$];
	blk_t     fwd_ref;
	int       cycle = 0;
	int       base;

	dft_rdx4_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got == want) else begin
			$display("CHECK FAILED %s got %h expected %h", name, got, want);
			abort_run();
		end
	endtask

	function automatic sample_t clip(input int v);
		if (v > SMAX) return sample_t'(SMAX);
		if (v < SMIN) return sample_t'(SMIN);
		return sample_t'(v);
	endfunction

	// reference butterfly built from the radix-4 rules
	function automatic blk_t predict_block(input sample_t re [4], input sample_t im [4],
			input dft_dir_e d, input margin_t m, input exp_t e);
		blk_t b;
		int y_re [4];
		int y_im [4];
		int od_re;
		int od_im;
		int r_re;
		int r_im;
		int sh;
		int ev;
		int v;
		b = '0;
		od_re = int'(re[1]) - int'(re[3]);
		od_im = int'(im[1]) - int'(im[3]);
		// odd difference times -j forward, +j inverse
		r_re = (d == DIR_FWD) ? od_im : -od_im;
		r_im = (d == DIR_FWD) ? -od_re : od_re;
		y_re[0] = int'(re[0]) + int'(re[2]) + int'(re[1]) + int'(re[3]);
		y_im[0] = int'(im[0]) + int'(im[2]) + int'(im[1]) + int'(im[3]);
		y_re[2] = int'(re[0]) + int'(re[2]) - int'(re[1]) - int'(re[3]);
		y_im[2] = int'(im[0]) + int'(im[2]) - int'(im[1]) - int'(im[3]);
		y_re[1] = int'(re[0]) - int'(re[2]) + r_re;
		y_im[1] = int'(im[0]) - int'(im[2]) + r_im;
		y_re[3] = int'(re[0]) - int'(re[2]) - r_re;
		y_im[3] = int'(im[0]) - int'(im[2]) - r_im;
		sh = `DFT_GROWTH - int'(m);
		if (sh < 0) sh = 0;
		for (int k = 0; k < 4; k++) begin
			v = y_re[k] >>> sh;
			b.re[k] = clip(v);
			if (v > SMAX || v < SMIN) b.ovf = 1'b1;
			v = y_im[k] >>> sh;
			b.im[k] = clip(v);
			if (v > SMAX || v < SMIN) b.ovf = 1'b1;
		end
		ev = int'(e) + sh;
		b.exponent = exp_t'((ev > EXP_MAX) ? EXP_MAX : ev);
		return b;
	endfunction

	task automatic fill_samples(input int lo, input int hi);
		for (int k = 0; k < 4; k++) begin
			stim_re[k] = sample_t'(lo + int'($urandom_range(0, hi - lo)));
			stim_im[k] = sample_t'(lo + int'($urandom_range(0, hi - lo)));
		end
	endtask

	task automatic send_block(input dft_dir_e d, input margin_t m, input exp_t e);
		@(posedge clk);
		in_val    <= 1'b1;
		dir       <= d;
		margin_in <= m;
		exp_in    <= e;
		for (int k = 0; k < 4; k++) begin
			din_re[k] <= stim_re[k];
			din_im[k] <= stim_im[k];
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_val <= 1'b0;
		end
	endtask

	task automatic wait_drain();
		idle_cycles(1);
		while (expect_q.size() != 0) @(posedge clk);
	endtask

	// outputs and inputs are sampled mid-cycle
	always @(negedge clk) begin
		blk_t want;
		blk_t got;
		if (out_val) begin
			if (expect_q.size() == 0) begin
				$display("out_val went high with no block in flight");
				abort_run();
			end
			want = expect_q.pop_front();
			assert (cycle - want.stamp == LATENCY) else begin
				$display("out_val came %0d cycles after in_val", cycle - want.stamp);
				abort_run();
			end
			got = '0;
			for (int k = 0; k < 4; k++) begin
				check_value($sformatf("dout_re[%0d]", k), 32'(dout_re[k]), 32'(want.re[k]));
				check_value($sformatf("dout_im[%0d]", k), 32'(dout_im[k]), 32'(want.im[k]));
				got.re[k] = dout_re[k];
				got.im[k] = dout_im[k];
			end
			check_value("exp_out", 32'(exp_out), 32'(want.exponent));
			check_value("ovf", 32'(ovf), 32'(want.ovf));
			got.exponent = exp_out;
			got.ovf = ovf;
			seen_q.push_back(got);
		end else begin
			check_value("ovf", 32'(ovf), 32'(1'b0));
		end
		if (rst_n && in_val) begin
			want = predict_block(din_re, din_im, dir, margin_in, exp_in);
			want.stamp = cycle;
			expect_q.push_back(want);
		end
	end

	initial begin
		while (cycle < TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
		abort_run();
	end

	initial begin
		void'($urandom(32'hdd40));
		rst_n = 1'b0;
		in_val = 1'b0;
		dir = DIR_FWD;
		margin_in = '0;
		exp_in = '0;
		for (int k = 0; k < 4; k++) begin
			din_re[k] = '0;
			din_im[k] = '0;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// quiet outputs after reset are checked by the monitor
		idle_cycles(5);

		// forward, margin 0, back to back
		base = seen_q.size();
		for (int i = 0; i < 8; i++) begin
			fill_samples(SMIN, SMAX);
			send_block(DIR_FWD, 2'd0, 4'd3);
		end
		wait_drain();
		for (int i = base; i < seen_q.size(); i++) begin
			check_value("exp_out", 32'(seen_q[i].exponent), 32'd5);
			check_value("ovf", 32'(seen_q[i].ovf), 32'd0);
		end

		// inverse swaps X1 and X3 of the forward result
		for (int i = 0; i < 4; i++) begin
			base = seen_q.size();
			fill_samples(SMIN, SMAX);
			fwd_ref = predict_block(stim_re, stim_im, DIR_FWD, 2'd0, 4'd2);
			send_block(DIR_FWD, 2'd0, 4'd2);
			send_block(DIR_INV, 2'd0, 4'd2);
			wait_drain();
			check_value("dout_re[1] inverse", 32'(seen_q[base + 1].re[1]),
				32'(fwd_ref.re[3]));
			check_value("dout_im[1] inverse", 32'(seen_q[base + 1].im[1]),
				32'(fwd_ref.im[3]));
			check_value("dout_re[3] inverse", 32'(seen_q[base + 1].re[3]),
				32'(fwd_ref.re[1]));
			check_value("dout_im[3] inverse", 32'(seen_q[base + 1].im[3]),
				32'(fwd_ref.im[1]));
		end

		// margin 2, saturation at both ends, then small values unshifted
		base = seen_q.size();
		fill_samples(SMAX, SMAX);
		send_block(DIR_FWD, 2'd2, 4'd7);
		fill_samples(SMIN, SMIN);
		send_block(DIR_INV, 2'd2, 4'd7);
		fill_samples(-4000, 4000);
		send_block(DIR_FWD, 2'd2, 4'd7);
		wait_drain();
		check_value("dout_re[0]", 32'(seen_q[base].re[0]), 32'(sample_t'(SMAX)));
		check_value("ovf", 32'(seen_q[base].ovf), 32'd1);
		check_value("dout_re[0]", 32'(seen_q[base + 1].re[0]), 32'(sample_t'(SMIN)));
		check_value("ovf", 32'(seen_q[base + 2].ovf), 32'd0);
		check_value("exp_out", 32'(seen_q[base + 2].exponent), 32'd7);

		// exponent sticks at its maximum
		base = seen_q.size();
		fill_samples(SMIN, SMAX);
		send_block(DIR_FWD, 2'd0, 4'd14);
		send_block(DIR_FWD, 2'd0, 4'd15);
		wait_drain();
		check_value("exp_out", 32'(seen_q[base].exponent), 32'(EXP_MAX));
		check_value("exp_out", 32'(seen_q[base + 1].exponent), 32'(EXP_MAX));

		// random traffic with gaps
		for (int i = 0; i < RAND_BLOCKS; i++) begin
			fill_samples(SMIN, SMAX);
			send_block(($urandom_range(0, 1) == 1) ? DIR_INV : DIR_FWD,
				margin_t'($urandom_range(0, 3)), exp_t'($urandom_range(0, EXP_MAX)));
			idle_cycles(int'($urandom_range(0, MAX_GAP)));
		end
		wait_drain();

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+source
source/dft_pkg.sv
source/radix2_pair_if.sv
source/radix2_stage.sv
source/radix4_combine.sv
source/dft_rdx4_top.sv
testbench/dft_rdx4_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dft_rdx4_tb
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
